// ==== source/mem_if_pkg.sv ====
// ==========================================================
// Memory port definitions shared by the request multiplexer
// Request and response beats with the widths of their fields
// ==========================================================

package mem_if_pkg;

    // Byte address of a read request
    typedef logic [31:0] addr_t;

    // Client tag that the memory echoes back with each response
    typedef logic [15:0] mdata_t;

    // One beat of read data
    typedef logic [63:0] rdata_t;

    // ==========================================================
    // Read request
    // ==========================================================

    // A request is a plain strobe, so valid is high for exactly one
    // cycle per request and the other fields matter only then
    typedef struct packed {
        logic   valid;
        addr_t  addr;
        mdata_t mdata;
    } mem_req_t;

    // ==========================================================
    // Read response
    // ==========================================================

    // The memory returns the request's mdata unchanged, which is what
    // lets the multiplexer route a response without extra storage
    typedef struct packed {
        logic   valid;
        mdata_t mdata;
        rdata_t data;
    } mem_rsp_t;

endpackage

// ==== source/mux_cfg_pkg.sv ====
// ==========================================================
// Configuration of the two-client request multiplexer
// ==========================================================

package mux_cfg_pkg;

    // Number of client ports behind the shared memory port
    localparam int NUM_CLIENTS = 2;

    // Mdata bit that carries the client index to the memory and back
    localparam int RESERVED_MDATA_IDX = 15;

    // Entries in each request buffer
    localparam int REQ_BUF_DEPTH = 4;

    // Almost-full rises when this many free entries or fewer remain
    localparam int REQ_BUF_ALM_FULL = 2;

    // Index of a client, as stored in the reserved mdata bit
    typedef logic [$clog2(NUM_CLIENTS)-1:0] client_idx_t;

    // Read and write pointers into a request buffer
    typedef logic [$clog2(REQ_BUF_DEPTH)-1:0] buf_ptr_t;

    // Fill count of a request buffer, from empty up to full
    typedef logic [$clog2(REQ_BUF_DEPTH+1)-1:0] buf_cnt_t;

    // Round-robin history, the client that won the last grant
    typedef enum logic {
        LAST_WAS_0 = 1'b0,
        LAST_WAS_1 = 1'b1
    } arb_state_t;

endpackage

// ==== source/req_buffer.sv ====
// ==========================================================
// Request buffer for one client port
// Small circular FIFO that decouples a client from the arbiter
// and flags almost-full back to the client
// ==========================================================

`timescale 1ns/1ns

module req_buffer
(
    input  logic                clk,
    input  logic                reset_n,
    input  mem_if_pkg::mem_req_t client_req,
    output logic                client_alm_full,
    output mem_if_pkg::mem_req_t head,
    input  logic                deq
);

    // Request storage, payload only, so it needs no reset
    mem_if_pkg::mem_req_t buf_mem [mux_cfg_pkg::REQ_BUF_DEPTH];

    mux_cfg_pkg::buf_ptr_t wr_ptr;
    mux_cfg_pkg::buf_ptr_t rd_ptr;
    mux_cfg_pkg::buf_cnt_t count;

    // Pointer increment that wraps at the buffer depth, so the depth
    // does not have to be a power of two
    function automatic mux_cfg_pkg::buf_ptr_t next_ptr(input mux_cfg_pkg::buf_ptr_t ptr);
        if (ptr == mux_cfg_pkg::buf_ptr_t'(mux_cfg_pkg::REQ_BUF_DEPTH - 1))
        begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // ==========================================================
    // Write and read side
    // ==========================================================

    always_ff @(posedge clk)
    begin
        if (client_req.valid)
        begin
            buf_mem[wr_ptr] <= client_req;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (client_req.valid)
            begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (deq)
            begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // A write and a dequeue in the same cycle leave the count alone
            if (client_req.valid && !deq)
            begin
                count <= count + 1'b1;
            end
            else if (!client_req.valid && deq)
            begin
                count <= count - 1'b1;
            end
        end
    end

    // The oldest entry is offered to the arbiter; valid means not empty
    always_comb
    begin
        head       = buf_mem[rd_ptr];
        head.valid = (count != '0);
    end

    // Derived from the registered count, so it rises the cycle after the
    // write that leaves REQ_BUF_ALM_FULL or fewer entries free
    assign client_alm_full = (count >= mux_cfg_pkg::buf_cnt_t'(
        mux_cfg_pkg::REQ_BUF_DEPTH - mux_cfg_pkg::REQ_BUF_ALM_FULL));

    // ==========================================================
    // Protocol checks
    // ==========================================================

    // The client must hold off while it sees almost-full
    a_alm_full_respected: assert property (@(posedge clk) disable iff (!reset_n)
        client_alm_full |-> !client_req.valid)
        else $error("req_buffer: client request while almost-full");

    a_no_write_when_full: assert property (@(posedge clk) disable iff (!reset_n)
        client_req.valid |-> (count != mux_cfg_pkg::buf_cnt_t'(mux_cfg_pkg::REQ_BUF_DEPTH)))
        else $error("req_buffer: write into a full buffer");

    // The arbiter may only dequeue a head that it saw as valid
    a_no_deq_when_empty: assert property (@(posedge clk) disable iff (!reset_n)
        deq |-> (count != '0))
        else $error("req_buffer: dequeue from an empty buffer");

endmodule

// ==== source/req_arbiter.sv ====
// ==========================================================
// Round-robin arbiter between two request buffer heads
// Tags the winner's mdata with its client index and drives
// the registered request toward the memory port
// ==========================================================

`timescale 1ns/1ns

module req_arbiter
(
    input  logic                clk,
    input  logic                reset_n,
    input  mem_if_pkg::mem_req_t head_0,
    input  mem_if_pkg::mem_req_t head_1,
    output logic                deq_0,
    output logic                deq_1,
    input  logic                mem_alm_full,
    output mem_if_pkg::mem_req_t mem_req
);

    // Client that won the most recent grant
    mux_cfg_pkg::arb_state_t last_winner;

    // Outcome of the current cycle
    logic                    grant;
    mux_cfg_pkg::client_idx_t winner;
    mem_if_pkg::mem_req_t    sel_head;
    mem_if_pkg::mdata_t      tagged_mdata;

    // Registered memory request
    logic                    req_valid_q;
    mem_if_pkg::addr_t       req_addr_q;
    mem_if_pkg::mdata_t      req_mdata_q;

    // ==========================================================
    // Winner selection
    // ==========================================================

    // Any valid head gets a grant unless the memory is almost full
    assign grant = (head_0.valid || head_1.valid) && !mem_alm_full;

    // With two clients round robin reduces to one expression.
    // Client 1 wins when it is alone, or when both ask and client 0 won last
    assign winner = head_1.valid && (!head_0.valid || (last_winner == mux_cfg_pkg::LAST_WAS_0));

    assign sel_head = (winner == 1'b1) ? head_1 : head_0;

    // The reserved bit arrives as zero and leaves carrying the winner's index
    always_comb
    begin
        tagged_mdata = sel_head.mdata;
        tagged_mdata[mux_cfg_pkg::RESERVED_MDATA_IDX] = winner;
    end

    // Dequeue strobes go out in the grant cycle itself
    assign deq_0 = grant && (winner == 1'b0);
    assign deq_1 = grant && (winner == 1'b1);

    // History only moves when something was actually granted
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            // Client 0 gets the first grant after reset
            last_winner <= mux_cfg_pkg::LAST_WAS_1;
        end
        else if (grant)
        begin
            last_winner <= (winner == 1'b1) ? mux_cfg_pkg::LAST_WAS_1 : mux_cfg_pkg::LAST_WAS_0;
        end
    end

    // ==========================================================
    // Memory request register
    // ==========================================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            req_valid_q <= 1'b0;
        end
        else
        begin
            req_valid_q <= grant;
        end
    end

    always_ff @(posedge clk)
    begin
        if (grant)
        begin
            req_addr_q  <= sel_head.addr;
            req_mdata_q <= tagged_mdata;
        end
    end

    assign mem_req = '{valid: req_valid_q, addr: req_addr_q, mdata: req_mdata_q};

    // ==========================================================
    // Checks
    // ==========================================================

    // The reserved bit would be overwritten, so a client must leave it zero
    a_reserved_bit_zero: assert property (@(posedge clk) disable iff (!reset_n)
        grant |-> (sel_head.mdata[mux_cfg_pkg::RESERVED_MDATA_IDX] == 1'b0))
        else $error("req_arbiter: client mdata[%0d] must be zero",
                    mux_cfg_pkg::RESERVED_MDATA_IDX);

    a_one_deq: assert property (@(posedge clk) disable iff (!reset_n)
        !(deq_0 && deq_1))
        else $error("req_arbiter: both buffers dequeued at once");

endmodule

// ==== source/rsp_router.sv ====
// ==========================================================
// Response router toward the two client ports
// Steers each memory response by its tag bit and clears it
// ==========================================================

`timescale 1ns/1ns

module rsp_router
(
    input  logic                clk,
    input  logic                reset_n,
    input  mem_if_pkg::mem_rsp_t mem_rsp,
    output mem_if_pkg::mem_rsp_t client_rsp_0,
    output mem_if_pkg::mem_rsp_t client_rsp_1
);

    // Client that the current memory response belongs to
    mux_cfg_pkg::client_idx_t rsp_idx;

    // Registered response, shared by both clients
    mem_if_pkg::mdata_t rsp_mdata_q;
    mem_if_pkg::rdata_t rsp_data_q;
    logic               rsp_valid_0_q;
    logic               rsp_valid_1_q;

    assign rsp_idx = mem_rsp.mdata[mux_cfg_pkg::RESERVED_MDATA_IDX];

    // Data and tag are broadcast; the valids pick the destination
    always_ff @(posedge clk)
    begin
        rsp_mdata_q <= mem_rsp.mdata;
        // The bit was zero when the client issued the request
        rsp_mdata_q[mux_cfg_pkg::RESERVED_MDATA_IDX] <= 1'b0;
        rsp_data_q  <= mem_rsp.data;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rsp_valid_0_q <= 1'b0;
            rsp_valid_1_q <= 1'b0;
        end
        else
        begin
            rsp_valid_0_q <= mem_rsp.valid && (rsp_idx == 1'b0);
            rsp_valid_1_q <= mem_rsp.valid && (rsp_idx == 1'b1);
        end
    end

    assign client_rsp_0 = '{valid: rsp_valid_0_q, mdata: rsp_mdata_q, data: rsp_data_q};
    assign client_rsp_1 = '{valid: rsp_valid_1_q, mdata: rsp_mdata_q, data: rsp_data_q};

    // A response belongs to exactly one client
    a_one_rsp_valid: assert property (@(posedge clk) disable iff (!reset_n)
        !(client_rsp_0.valid && client_rsp_1.valid))
        else $error("rsp_router: response delivered to both clients");

endmodule

// ==== source/client_mux_top.sv ====
// ==========================================================
// Two-client read request multiplexer
// Buffers each client, arbitrates onto one memory port and
// routes the responses back by the reserved mdata bit
// ==========================================================

`timescale 1ns/1ns

module client_mux_top
(
    input  logic                clk,
    input  logic                reset_n,
    input  mem_if_pkg::mem_req_t client_req_0,
    input  mem_if_pkg::mem_req_t client_req_1,
    output logic                client_alm_full_0,
    output logic                client_alm_full_1,
    output mem_if_pkg::mem_rsp_t client_rsp_0,
    output mem_if_pkg::mem_rsp_t client_rsp_1,
    output mem_if_pkg::mem_req_t mem_req,
    input  logic                mem_alm_full,
    input  mem_if_pkg::mem_rsp_t mem_rsp
);

    // Buffer heads offered to the arbiter and its dequeue strobes
    mem_if_pkg::mem_req_t head_0;
    mem_if_pkg::mem_req_t head_1;
    logic                 deq_0;
    logic                 deq_1;

    // ==========================================================
    // Request path
    // ==========================================================

    req_buffer u_buf_0
    (
        .clk             (clk),
        .reset_n         (reset_n),
        .client_req      (client_req_0),
        .client_alm_full (client_alm_full_0),
        .head            (head_0),
        .deq             (deq_0)
    );

    req_buffer u_buf_1
    (
        .clk             (clk),
        .reset_n         (reset_n),
        .client_req      (client_req_1),
        .client_alm_full (client_alm_full_1),
        .head            (head_1),
        .deq             (deq_1)
    );

    req_arbiter u_arbiter
    (
        .clk          (clk),
        .reset_n      (reset_n),
        .head_0       (head_0),
        .head_1       (head_1),
        .deq_0        (deq_0),
        .deq_1        (deq_1),
        .mem_alm_full (mem_alm_full),
        .mem_req      (mem_req)
    );

    // ==========================================================
    // Response path
    // ==========================================================

    rsp_router u_router
    (
        .clk          (clk),
        .reset_n      (reset_n),
        .mem_rsp      (mem_rsp),
        .client_rsp_0 (client_rsp_0),
        .client_rsp_1 (client_rsp_1)
    );

endmodule

// ==== tb/mem_responder.sv ====
// ==========================================================
// Behavioral memory for the multiplexer testbench
// Answers read requests in order after random gaps
// ==========================================================

`timescale 1ns/1ns

module mem_responder
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  mem_if_pkg::mem_req_t mem_req,
    input  logic                 hold_alm_full,
    output logic                 mem_alm_full,
    output mem_if_pkg::mem_rsp_t mem_rsp
);

    // Requests accepted and not yet answered, oldest first
    mem_if_pkg::mem_req_t pending_q [$];

    // Stream of random decisions for this model
    integer seed = 32'h3bc1649d;

    logic                 rand_alm_full = 1'b0;
    mem_if_pkg::mem_rsp_t rsp_out = '0;
    mem_if_pkg::mem_req_t cur_req;
    logic                 in_reset;

    // The request register of the DUT is stable at the falling edge
    always @(negedge clk)
    begin
        if (reset_n && mem_req.valid)
        begin
            pending_q.push_back(mem_req);
        end
    end

    // Outputs change a little after the rising edge, like the other stimulus
    always @(posedge clk)
    begin
        in_reset = !reset_n;
        #2;
        if (in_reset)
        begin
            pending_q.delete();
            rand_alm_full = 1'b0;
            rsp_out       = '0;
        end
        else
        begin
            // Almost-full is high in about one cycle of four
            rand_alm_full = (($random(seed) & 3) == 0);
            rsp_out = '0;
            if ((pending_q.size() != 0) && (($random(seed) & 1) == 1))
            begin
                cur_req = pending_q.pop_front();
                // Data is the address followed by its inverse
                rsp_out = '{valid: 1'b1, mdata: cur_req.mdata,
                            data: {cur_req.addr, ~cur_req.addr}};
            end
        end
    end

    // The testbench can force back-pressure for its directed phase
    assign mem_alm_full = hold_alm_full || rand_alm_full;
    assign mem_rsp      = rsp_out;

endmodule

// ==== tb/client_mux_tb.sv ====
// ==========================================================
// Testbench for the two-client request multiplexer
// Random traffic, in-order checks per client, back-pressure
// and a directed round-robin fairness phase
// ==========================================================

`timescale 1ns/1ns

module client_mux_tb;

    // Random requests per client, then a few more in the fairness phase
    localparam int RAND_REQS   = 200;
    localparam int TOTAL_REQS  = 2 * (RAND_REQS + mux_cfg_pkg::REQ_BUF_DEPTH);
    localparam int WATCHDOG_CYCLES = TOTAL_REQS * 40 + 200;
    localparam int RES_BIT     = mux_cfg_pkg::RESERVED_MDATA_IDX;

    logic clk = 1'b0;
    logic reset_n;
    mem_if_pkg::mem_req_t client_req_0;
    mem_if_pkg::mem_req_t client_req_1;
    logic client_alm_full_0;
    logic client_alm_full_1;
    mem_if_pkg::mem_rsp_t client_rsp_0;
    mem_if_pkg::mem_rsp_t client_rsp_1;
    mem_if_pkg::mem_req_t mem_req;
    logic mem_alm_full;
    mem_if_pkg::mem_rsp_t mem_rsp;
    logic hold_alm_full;

    integer seed = 32'h3bc1649d;

    // Requests waiting to appear on mem_req, then waiting for a response
    mem_if_pkg::mem_req_t exp_fwd_0 [$];
    mem_if_pkg::mem_req_t exp_fwd_1 [$];
    mem_if_pkg::mem_req_t exp_rsp_0 [$];
    mem_if_pkg::mem_req_t exp_rsp_1 [$];
    int issued [2];
    int responded [2];

    // Back-pressure history and round-robin tracking
    logic prev_alm_full = 1'b0;
    logic last_tag = 1'b1;
    logic fair_next_tag = 1'b0;
    int   fair_left = 0;

    always #10 clk = ~clk;

    client_mux_top uut
    (
        .clk               (clk),
        .reset_n           (reset_n),
        .client_req_0      (client_req_0),
        .client_req_1      (client_req_1),
        .client_alm_full_0 (client_alm_full_0),
        .client_alm_full_1 (client_alm_full_1),
        .client_rsp_0      (client_rsp_0),
        .client_rsp_1      (client_rsp_1),
        .mem_req           (mem_req),
        .mem_alm_full      (mem_alm_full),
        .mem_rsp           (mem_rsp)
    );

    mem_responder u_mem
    (
        .clk           (clk),
        .reset_n       (reset_n),
        .mem_req       (mem_req),
        .hold_alm_full (hold_alm_full),
        .mem_alm_full  (mem_alm_full),
        .mem_rsp       (mem_rsp)
    );

    // ==========================================================
    // Reporting
    // ==========================================================

    task automatic stop_with_failure();
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    // All outputs that reset clears must be low
    task automatic check_idle();
        check_value("mem_req.valid", 64'(mem_req.valid), 64'd0);
        check_value("client_rsp_0.valid", 64'(client_rsp_0.valid), 64'd0);
        check_value("client_rsp_1.valid", 64'(client_rsp_1.valid), 64'd0);
        check_value("client_alm_full_0", 64'(client_alm_full_0), 64'd0);
        check_value("client_alm_full_1", 64'(client_alm_full_1), 64'd0);
    endtask

    // ==========================================================
    // Client stimulus
    // ==========================================================

    // Issues one request when the buffer has room, the limit is not
    // reached and the coin says so, otherwise drives an idle cycle
    task automatic drive_client(input int idx, input int limit, input bit always_issue);
        logic [31:0]          rnd;
        logic                 alm_full;
        mem_if_pkg::mem_req_t req;
        alm_full = (idx == 0) ? client_alm_full_0 : client_alm_full_1;
        rnd = $random(seed);
        req = '0;
        if (!alm_full && (issued[idx] < limit) && (always_issue || (rnd[1:0] != 2'b00)))
        begin
            req.valid = 1'b1;
            req.addr  = $random(seed);
            rnd       = $random(seed);
            req.mdata = rnd[15:0];
            req.mdata[RES_BIT] = 1'b0;
            if (idx == 0)
                exp_fwd_0.push_back(req);
            else
                exp_fwd_1.push_back(req);
            issued[idx]++;
        end
        if (idx == 0)
            client_req_0 = req;
        else
            client_req_1 = req;
    endtask

    task automatic wait_drain();
        while (responded[0] + responded[1] != issued[0] + issued[1])
        begin
            @(posedge clk);
        end
    endtask

    // ==========================================================
    // Output checking at the falling edge
    // ==========================================================

    task automatic match_mem_req(input mem_if_pkg::mem_req_t got);
        mem_if_pkg::mem_req_t exp;
        logic                 tag;
        tag = got.mdata[RES_BIT];
        if ((tag == 1'b0) ? (exp_fwd_0.size() == 0) : (exp_fwd_1.size() == 0))
        begin
            $display("ERROR at %0t ns: mem_req tagged for client %0d, which has nothing pending",
                     $time, tag);
            stop_with_failure();
        end
        if (tag == 1'b0)
        begin
            exp = exp_fwd_0.pop_front();
            exp_rsp_0.push_back(exp);
        end
        else
        begin
            exp = exp_fwd_1.pop_front();
            exp_rsp_1.push_back(exp);
        end
        // The forwarded copy carries the client index in the reserved bit
        exp.mdata[RES_BIT] = tag;
        check_value("mem_req.addr", 64'(got.addr), 64'(exp.addr));
        check_value("mem_req.mdata", 64'(got.mdata), 64'(exp.mdata));
        if (fair_left > 0)
        begin
            check_value("mem_req fairness tag", 64'(tag), 64'(fair_next_tag));
            fair_next_tag = ~fair_next_tag;
            fair_left--;
        end
        last_tag = tag;
    endtask

    task automatic match_rsp(input int idx, input mem_if_pkg::mem_rsp_t got);
        mem_if_pkg::mem_req_t exp;
        if ((idx == 0) ? (exp_rsp_0.size() == 0) : (exp_rsp_1.size() == 0))
        begin
            $display("ERROR at %0t ns: response on client %0d with no request in flight",
                     $time, idx);
            stop_with_failure();
        end
        exp = (idx == 0) ? exp_rsp_0.pop_front() : exp_rsp_1.pop_front();
        check_value($sformatf("client_rsp_%0d.mdata", idx), 64'(got.mdata), 64'(exp.mdata));
        check_value($sformatf("client_rsp_%0d.data", idx), got.data, {exp.addr, ~exp.addr});
        responded[idx]++;
    endtask

    // A buffer holds what was issued and not yet forwarded
    // except the request that is being written in this cycle
    task automatic expect_alm_full();
        int free_0;
        int free_1;
        free_0 = mux_cfg_pkg::REQ_BUF_DEPTH - (exp_fwd_0.size() - int'(client_req_0.valid));
        free_1 = mux_cfg_pkg::REQ_BUF_DEPTH - (exp_fwd_1.size() - int'(client_req_1.valid));
        // Almost-full is high while only a few entries are free
        check_value("client_alm_full_0", 64'(client_alm_full_0),
                    64'(free_0 <= mux_cfg_pkg::REQ_BUF_ALM_FULL));
        check_value("client_alm_full_1", 64'(client_alm_full_1),
                    64'(free_1 <= mux_cfg_pkg::REQ_BUF_ALM_FULL));
    endtask

    always @(negedge clk)
    begin
        if (reset_n)
        begin
            // Memory back-pressure in one cycle blocks mem_req in the next
            if (prev_alm_full)
                check_value("mem_req.valid after mem_alm_full", 64'(mem_req.valid), 64'd0);
            if (mem_req.valid)
                match_mem_req(mem_req);
            if (client_rsp_0.valid)
                match_rsp(0, client_rsp_0);
            if (client_rsp_1.valid)
                match_rsp(1, client_rsp_1);
            expect_alm_full();
        end
        prev_alm_full = mem_alm_full;
    end

    // Ends a run that stops making progress
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles, traffic stopped flowing",
                 WATCHDOG_CYCLES);
        stop_with_failure();
    end

    // ==========================================================
    // Test sequence
    // ==========================================================

    initial
    begin
        reset_n       = 1'b0;
        client_req_0  = '0;
        client_req_1  = '0;
        hold_alm_full = 1'b0;
        issued        = '{0, 0};
        responded     = '{0, 0};

        // Sixteen rising edges in reset, outputs idle from the first one
        @(posedge clk);
        repeat (15)
        begin
            @(negedge clk);
            check_idle();
            @(posedge clk);
        end
        #2;
        reset_n = 1'b1;
        @(negedge clk);
        check_idle();

        // Random traffic on both clients
        while ((issued[0] < RAND_REQS) || (issued[1] < RAND_REQS))
        begin
            @(posedge clk);
            #2;
            drive_client(0, RAND_REQS, 1'b0);
            drive_client(1, RAND_REQS, 1'b0);
        end
        @(posedge clk);
        #2;
        client_req_0 = '0;
        client_req_1 = '0;
        wait_drain();

        // Fill both buffers to almost-full while memory holds off
        @(posedge clk);
        #2;
        hold_alm_full = 1'b1;
        while (!client_alm_full_0 || !client_alm_full_1)
        begin
            drive_client(0, RAND_REQS + mux_cfg_pkg::REQ_BUF_DEPTH, 1'b1);
            drive_client(1, RAND_REQS + mux_cfg_pkg::REQ_BUF_DEPTH, 1'b1);
            @(posedge clk);
            #2;
        end
        client_req_0 = '0;
        client_req_1 = '0;

        // Both heads stay valid until the shorter queue runs out
        fair_left     = 2 * ((issued[0] < issued[1] ? issued[0] : issued[1]) - RAND_REQS);
        fair_next_tag = ~last_tag;
        hold_alm_full = 1'b0;
        wait_drain();

        check_value("fairness beats left", 64'(fair_left), 64'd0);
        check_value("responses for client 0", 64'(responded[0]), 64'(issued[0]));
        check_value("responses for client 1", 64'(responded[1]), 64'(issued[1]));
        $display("No errors");
        $finish;
    end

endmodule

// ==== client_mux_top.f ====
source/mem_if_pkg.sv
source/mux_cfg_pkg.sv
source/req_buffer.sv
source/req_arbiter.sv
source/rsp_router.sv
source/client_mux_top.sv
tb/mem_responder.sv
tb/client_mux_tb.sv

// ==== Makefile ====
# Verilator simulation of the two-client request multiplexer
# Any variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= client_mux_tb
FILELIST  ?= client_mux_top.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal
EXTRA     ?=

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: sim clean

# Builds and runs; the exit status is nonzero when the testbench fails
sim:
	$(VERILATOR) $(VFLAGS) $(EXTRA) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
